// ==== hdl/lc3b_defs.svh ====
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// Data and address word width
`define LC3B_WORD_W 16

// Memory depth in 16-bit words
// Word index comes from the byte address bits above bit 0
`define LC3B_MEM_WORDS 256

// Opcode field of the instruction word
`define LC3B_OPC_MSB 15
`define LC3B_OPC_LSB 12

`endif

// ==== hdl/lc3b_pkg.sv ====
`default_nettype none
`include "lc3b_defs.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;
    // Bit 1 enables the high byte
    typedef logic [1:0] lc3b_mask;

    typedef enum logic [`LC3B_OPC_MSB-`LC3B_OPC_LSB:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        marmux_alu,
        marmux_pc,
        marmux_br_add,
        marmux_mem_word,
        marmux_trap_vector,
        marmux_indirect
    } marmux_sel_e;

    typedef enum logic [1:0] {
        mdrmux_alu,
        mdrmux_sr1_high,
        mdrmux_sr2,
        mdrmux_sr2_byte
    } mdrmux_sel_e;

    typedef enum logic [2:0] {
        regfilemux_alu,
        regfilemux_mem_word,
        regfilemux_br_add,
        regfilemux_pc,
        regfilemux_byte_zext,
        regfilemux_shift,
        regfilemux_ldb_zext
    } regfilemux_sel_e;

    typedef struct packed {
        lc3b_opcode      opcode;
        logic            mem_read;
        logic            mem_write;
        lc3b_mask        mem_byte_enable;
        marmux_sel_e     marmux_sel;
        mdrmux_sel_e     mdrmux_sel;
        regfilemux_sel_e regfilemux_sel;
        logic            load_cc;
    } lc3b_ctrl_word;

    typedef struct packed {
        logic     read;
        logic     write;
        lc3b_word addr;
        lc3b_word wdata;
        lc3b_mask wmask;
    } mem_req_t;

endpackage : lc3b_pkg

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter (
    input  wire                clk,
    input  wire                rst_n,
    input  wire lc3b_pkg::mem_req_t data_req,
    input  wire lc3b_pkg::mem_req_t fetch_req,
    output logic               data_resp,
    output logic               fetch_resp,
    output lc3b_pkg::mem_req_t mem_req,
    input  wire                mem_resp
);

    typedef enum logic {
        st_idle,
        st_busy
    } arb_state_e;

    arb_state_e state;
    logic       owner_data;   // high when the data port holds the memory
    logic       data_ask;
    logic       fetch_ask;

    assign data_ask  = data_req.read | data_req.write;
    assign fetch_ask = fetch_req.read | fetch_req.write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            owner_data <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (data_ask || fetch_ask) begin
                        state      <= st_busy;
                        owner_data <= data_ask;
                    end
                end
                st_busy: begin
                    if (mem_resp) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Data port has priority when both ask in the same idle cycle
    always_comb begin
        mem_req = '0;
        if (state == st_idle) begin
            if (data_ask) begin
                mem_req = data_req;
            end else if (fetch_ask) begin
                mem_req = fetch_req;
            end
        end else if (owner_data) begin
            mem_req = data_req;
        end else begin
            mem_req = fetch_req;
        end
    end

    assign data_resp  = (state == st_busy) && owner_data && mem_resp;
    assign fetch_resp = (state == st_busy) && !owner_data && mem_resp;

endmodule : mem_arbiter

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire lc3b_pkg::lc3b_ctrl_word ctrl,
    input  wire lc3b_pkg::lc3b_word alu_out,
    input  wire lc3b_pkg::lc3b_word pc_out,
    input  wire lc3b_pkg::lc3b_word br_add_out,
    input  wire lc3b_pkg::lc3b_word sr1_out,
    input  wire lc3b_pkg::lc3b_word sr2_out,
    input  wire lc3b_pkg::lc3b_word instruction,
    output lc3b_pkg::mem_req_t      data_req,
    input  wire                     data_resp,
    input  wire lc3b_pkg::lc3b_word rdata,
    output logic                    stall
);

    logic                  is_indirect;
    logic                  is_sti;
    logic                  is_stb;
    logic                  ind_flag;
    lc3b_pkg::lc3b_word    ind_ptr;
    lc3b_pkg::lc3b_word    trap_vector;
    lc3b_pkg::lc3b_word    addr;
    lc3b_pkg::lc3b_word    wdata;
    lc3b_pkg::lc3b_word    stb_data;
    lc3b_pkg::lc3b_mask    wmask;
    lc3b_pkg::marmux_sel_e mar_sel;
    lc3b_pkg::mdrmux_sel_e mdr_sel;
    logic                  rd;
    logic                  wr;

    assign is_indirect = (ctrl.opcode == lc3b_pkg::op_ldi) ||
                         (ctrl.opcode == lc3b_pkg::op_sti);
    assign is_sti      = (ctrl.opcode == lc3b_pkg::op_sti);
    assign is_stb      = (ctrl.opcode == lc3b_pkg::op_stb);

    assign trap_vector = {7'b0, instruction[7:0], 1'b0};

    // Indirect: pointer fetch from the ALU address, then the captured pointer
    always_comb begin
        if (is_indirect && !ind_flag) begin
            mar_sel = lc3b_pkg::marmux_alu;
        end else if (is_indirect) begin
            mar_sel = lc3b_pkg::marmux_indirect;
        end else begin
            mar_sel = ctrl.marmux_sel;
        end
    end

    always_comb begin
        case (mar_sel)
            lc3b_pkg::marmux_pc:          addr = pc_out;
            lc3b_pkg::marmux_br_add:      addr = br_add_out;
            lc3b_pkg::marmux_mem_word:    addr = rdata;
            lc3b_pkg::marmux_trap_vector: addr = trap_vector;
            lc3b_pkg::marmux_indirect:    addr = ind_ptr;
            default:                      addr = alu_out;
        endcase
    end

    // Store byte goes to the lane picked by the address
    assign stb_data = addr[0] ? {sr2_out[7:0], 8'h00} : {8'h00, sr2_out[7:0]};

    always_comb begin
        if (is_sti) begin
            mdr_sel = lc3b_pkg::mdrmux_sr2;
        end else if (is_stb) begin
            mdr_sel = lc3b_pkg::mdrmux_sr2_byte;
        end else begin
            mdr_sel = ctrl.mdrmux_sel;
        end
    end

    always_comb begin
        case (mdr_sel)
            lc3b_pkg::mdrmux_sr1_high: wdata = sr1_out << 8;
            lc3b_pkg::mdrmux_sr2:      wdata = sr2_out;
            lc3b_pkg::mdrmux_sr2_byte: wdata = stb_data;
            default:                   wdata = alu_out;
        endcase
    end

    always_comb begin
        if (is_stb) begin
            wmask = addr[0] ? 2'b10 : 2'b01;
        end else if (is_indirect) begin
            wmask = 2'b11;
        end else begin
            wmask = ctrl.mem_byte_enable;
        end
    end

    // STI reads the pointer first and writes on the second access
    always_comb begin
        if (is_indirect && !ind_flag) begin
            rd = 1'b1;
            wr = 1'b0;
        end else if (is_indirect) begin
            rd = !is_sti;
            wr = is_sti;
        end else begin
            rd = ctrl.mem_read;
            wr = ctrl.mem_write;
        end
    end

    assign data_req.read  = rd;
    assign data_req.write = wr;
    assign data_req.addr  = addr;
    assign data_req.wdata = wdata;
    assign data_req.wmask = wmask;

    assign stall = ((rd | wr) & ~data_resp) | (is_indirect & ~ind_flag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ind_flag <= 1'b0;
        end else if (is_indirect && data_resp) begin
            ind_flag <= ~ind_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (is_indirect && data_resp && !ind_flag) begin
            ind_ptr <= rdata;
        end
    end

endmodule : mem_stage

`default_nettype wire

// ==== hdl/mem_subsystem.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire lc3b_pkg::lc3b_ctrl_word ctrl,
    input  wire lc3b_pkg::lc3b_word alu_out,
    input  wire lc3b_pkg::lc3b_word pc_out,
    input  wire lc3b_pkg::lc3b_word br_add_out,
    input  wire lc3b_pkg::lc3b_word sr1_out,
    input  wire lc3b_pkg::lc3b_word sr2_out,
    input  wire lc3b_pkg::lc3b_word instruction,
    input  wire lc3b_pkg::lc3b_reg  dest,
    input  wire lc3b_pkg::mem_req_t fetch_req,
    output logic                    fetch_resp,
    output lc3b_pkg::lc3b_word      fetch_rdata,
    output lc3b_pkg::lc3b_word      regfilemux_out,
    output lc3b_pkg::lc3b_word      trap_mem,
    output lc3b_pkg::lc3b_word      br_count,
    output lc3b_pkg::lc3b_word      br_taken_count,
    output logic                    br_en,
    output logic                    jmp_jsr_en,
    output logic                    trap_en,
    output logic                    b11,
    output logic                    stall
);

    lc3b_pkg::mem_req_t data_req;
    lc3b_pkg::mem_req_t mem_req;
    lc3b_pkg::lc3b_word mem_rdata;
    logic               data_resp;
    logic               mem_resp;

    // Read data is shared by both ports
    assign fetch_rdata = mem_rdata;

    mem_stage i_mem_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .alu_out     (alu_out),
        .pc_out      (pc_out),
        .br_add_out  (br_add_out),
        .sr1_out     (sr1_out),
        .sr2_out     (sr2_out),
        .instruction (instruction),
        .data_req    (data_req),
        .data_resp   (data_resp),
        .rdata       (mem_rdata),
        .stall       (stall)
    );

    writeback_select i_writeback_select (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .alu_out        (alu_out),
        .pc_out         (pc_out),
        .br_add_out     (br_add_out),
        .sr1_out        (sr1_out),
        .instruction    (instruction),
        .dest           (dest),
        .rdata          (mem_rdata),
        .data_resp      (data_resp),
        .stall          (stall),
        .addr_lsb       (data_req.addr[0]),
        .regfilemux_out (regfilemux_out),
        .trap_mem       (trap_mem),
        .br_count       (br_count),
        .br_taken_count (br_taken_count),
        .br_en          (br_en),
        .jmp_jsr_en     (jmp_jsr_en),
        .trap_en        (trap_en),
        .b11            (b11)
    );

    mem_arbiter i_mem_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_req   (data_req),
        .fetch_req  (fetch_req),
        .data_resp  (data_resp),
        .fetch_resp (fetch_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

    unified_mem i_unified_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .resp  (mem_resp),
        .rdata (mem_rdata)
    );

endmodule : mem_subsystem

`default_nettype wire

// ==== hdl/unified_mem.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module unified_mem (
    input  wire                clk,
    input  wire                rst_n,
    input  wire lc3b_pkg::mem_req_t req,
    output logic               resp,
    output lc3b_pkg::lc3b_word rdata
);

    localparam int ADDR_W = $clog2(`LC3B_MEM_WORDS);

    lc3b_pkg::lc3b_word mem [`LC3B_MEM_WORDS];
    logic [ADDR_W-1:0]  word_addr;
    logic               access;

    assign word_addr = req.addr[ADDR_W:1];

    // A request still held in the response cycle is not served again
    assign access = (req.read | req.write) & ~resp;

    always_ff @(posedge clk) begin
        if (access) begin
            if (req.write) begin
                if (req.wmask[0]) begin
                    mem[word_addr][7:0] <= req.wdata[7:0];
                end
                if (req.wmask[1]) begin
                    mem[word_addr][15:8] <= req.wdata[15:8];
                end
            end else begin
                rdata <= mem[word_addr];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp <= 1'b0;
        end else begin
            resp <= access;
        end
    end

endmodule : unified_mem

`default_nettype wire

// ==== hdl/writeback_select.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module writeback_select (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire lc3b_pkg::lc3b_ctrl_word ctrl,
    input  wire lc3b_pkg::lc3b_word alu_out,
    input  wire lc3b_pkg::lc3b_word pc_out,
    input  wire lc3b_pkg::lc3b_word br_add_out,
    input  wire lc3b_pkg::lc3b_word sr1_out,
    input  wire lc3b_pkg::lc3b_word instruction,
    input  wire lc3b_pkg::lc3b_reg  dest,
    input  wire lc3b_pkg::lc3b_word rdata,
    input  wire                     data_resp,
    input  wire                     stall,
    input  wire                     addr_lsb,
    output lc3b_pkg::lc3b_word      regfilemux_out,
    output lc3b_pkg::lc3b_word      trap_mem,
    output lc3b_pkg::lc3b_word      br_count,
    output lc3b_pkg::lc3b_word      br_taken_count,
    output logic                    br_en,
    output logic                    jmp_jsr_en,
    output logic                    trap_en,
    output logic                    b11
);

    lc3b_pkg::lc3b_word shift_out;
    lc3b_pkg::lc3b_word ldb_zext;
    lc3b_pkg::lc3b_nzp  gen_cc;
    lc3b_pkg::lc3b_nzp  cc;
    logic [7:0]         ldb_byte;
    logic               advance;

    assign ldb_byte = addr_lsb ? rdata[15:8] : rdata[7:0];
    assign ldb_zext = {8'h00, ldb_byte};

    // SHF: bit 4 picks right shift, bit 5 makes it arithmetic
    always_comb begin
        if (!instruction[4]) begin
            shift_out = sr1_out << instruction[3:0];
        end else if (!instruction[5]) begin
            shift_out = sr1_out >> instruction[3:0];
        end else begin
            shift_out = $signed(sr1_out) >>> instruction[3:0];
        end
    end

    always_comb begin
        case (ctrl.regfilemux_sel)
            lc3b_pkg::regfilemux_mem_word:  regfilemux_out = rdata;
            lc3b_pkg::regfilemux_br_add:    regfilemux_out = br_add_out;
            lc3b_pkg::regfilemux_pc:        regfilemux_out = pc_out;
            lc3b_pkg::regfilemux_byte_zext: regfilemux_out = {8'h00, rdata[7:0]};
            lc3b_pkg::regfilemux_shift:     regfilemux_out = shift_out;
            lc3b_pkg::regfilemux_ldb_zext:  regfilemux_out = ldb_zext;
            default:                        regfilemux_out = alu_out;
        endcase
    end

    assign gen_cc[2] = regfilemux_out[`LC3B_WORD_W-1];
    assign gen_cc[1] = (regfilemux_out == '0);
    assign gen_cc[0] = !gen_cc[2] && !gen_cc[1];

    // State moves only when the stage is not stalled
    assign advance = !stall;

    assign br_en      = (ctrl.opcode == lc3b_pkg::op_br) && |(dest & cc);
    assign jmp_jsr_en = (ctrl.opcode == lc3b_pkg::op_jmp) ||
                        (ctrl.opcode == lc3b_pkg::op_jsr);
    assign trap_en    = (ctrl.opcode == lc3b_pkg::op_trap) && data_resp;
    assign trap_mem   = trap_en ? rdata : '0;
    assign b11        = instruction[11];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc             <= 3'b010;
            br_count       <= '0;
            br_taken_count <= '0;
        end else if (advance) begin
            if (ctrl.load_cc) begin
                cc <= gen_cc;
            end
            if (ctrl.opcode == lc3b_pkg::op_br) begin
                br_count <= br_count + 1'b1;
            end
            if (br_en) begin
                br_taken_count <= br_taken_count + 1'b1;
            end
        end
    end

endmodule : writeback_select

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal \
    --top-module tb_mem_subsystem \
    -Mdir "$OBJ" \
    -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vtb_mem_subsystem" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi

exit 0

// ==== sim.f ====
+incdir+hdl
hdl/lc3b_pkg.sv
hdl/mem_arbiter.sv
hdl/unified_mem.sv
hdl/mem_stage.sv
hdl/writeback_select.sv
hdl/mem_subsystem.sv
sim/tb_mem_subsystem.sv

// ==== sim/tb_mem_subsystem.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module tb_mem_subsystem;

    localparam int N_MAX = 64;

    logic clk = 1'b0;
    logic rst_n;
    lc3b_pkg::lc3b_ctrl_word ctrl;
    lc3b_pkg::lc3b_word alu_out, pc_out, br_add_out, sr1_out, sr2_out, instruction;
    lc3b_pkg::lc3b_reg dest;
    lc3b_pkg::mem_req_t fetch_req;
    logic fetch_resp, br_en, jmp_jsr_en, trap_en, b11, stall;
    lc3b_pkg::lc3b_word fetch_rdata, regfilemux_out, trap_mem, br_count, br_taken_count;

    // Stimulus table, one row per test
    lc3b_pkg::lc3b_opcode t_op [N_MAX];
    lc3b_pkg::lc3b_word   t_addr [N_MAX];
    lc3b_pkg::lc3b_word   t_data [N_MAX];
    lc3b_pkg::lc3b_word   t_src [N_MAX];
    lc3b_pkg::lc3b_word   t_instr [N_MAX];
    lc3b_pkg::lc3b_word   t_exp [N_MAX];
    lc3b_pkg::lc3b_reg    t_dest [N_MAX];
    logic                 t_fetch [N_MAX];
    int n_tests = 0;
    logic table_ready = 1'b0;

    lc3b_pkg::lc3b_word shadow [`LC3B_MEM_WORDS];
    int written [$];
    lc3b_pkg::lc3b_nzp cc_model = 3'b010;
    lc3b_pkg::lc3b_word br_tally = '0;
    lc3b_pkg::lc3b_word taken_tally = '0;
    logic fetch_on = 1'b0;
    int test_errs, pass_cnt = 0, fail_cnt = 0, fetch_errs = 0, fetch_cnt = 0;
    int stray_errs = 0;

    mem_subsystem i_dut (.*);

    always #5 clk = ~clk;

    function automatic int widx(lc3b_pkg::lc3b_word a);
        return int'(a[8:1]);
    endfunction

    // Bit by bit SHF model: left fills zero, right fills zero or the sign
    function automatic lc3b_pkg::lc3b_word shift_ref(lc3b_pkg::lc3b_word v,
                                                     lc3b_pkg::lc3b_word ins);
        lc3b_pkg::lc3b_word r;
        int s;
        int src;
        s = int'(ins[3:0]);
        for (int j = 0; j < 16; j++) begin
            if (!ins[4]) begin
                src = j - s;
            end else begin
                src = j + s;
            end
            if (src >= 0 && src < 16) begin
                r[j] = v[src];
            end else begin
                r[j] = ins[4] & ins[5] & v[15];
            end
        end
        return r;
    endfunction

    function automatic lc3b_pkg::lc3b_ctrl_word decode_ctrl(lc3b_pkg::lc3b_opcode op);
        lc3b_pkg::lc3b_ctrl_word c;
        c = '0;
        c.opcode = op;
        c.mem_byte_enable = 2'b11;
        c.marmux_sel = lc3b_pkg::marmux_alu;
        c.mdrmux_sel = lc3b_pkg::mdrmux_alu;
        c.regfilemux_sel = lc3b_pkg::regfilemux_alu;
        case (op)
            lc3b_pkg::op_add: c.load_cc = 1'b1;
            lc3b_pkg::op_ldr, lc3b_pkg::op_ldi: begin
                c.mem_read = 1'b1;
                c.regfilemux_sel = lc3b_pkg::regfilemux_mem_word;
            end
            lc3b_pkg::op_ldb: begin
                c.mem_read = 1'b1;
                c.regfilemux_sel = lc3b_pkg::regfilemux_ldb_zext;
            end
            lc3b_pkg::op_str, lc3b_pkg::op_sti: begin
                c.mem_write = 1'b1;
                c.mdrmux_sel = lc3b_pkg::mdrmux_sr2;
            end
            lc3b_pkg::op_stb: begin
                c.mem_write = 1'b1;
                c.mdrmux_sel = lc3b_pkg::mdrmux_sr2_byte;
            end
            lc3b_pkg::op_lea: c.regfilemux_sel = lc3b_pkg::regfilemux_br_add;
            lc3b_pkg::op_jsr: c.regfilemux_sel = lc3b_pkg::regfilemux_pc;
            lc3b_pkg::op_shf: c.regfilemux_sel = lc3b_pkg::regfilemux_shift;
            lc3b_pkg::op_trap: begin
                c.mem_read = 1'b1;
                c.marmux_sel = lc3b_pkg::marmux_trap_vector;
                c.regfilemux_sel = lc3b_pkg::regfilemux_pc;
            end
            default: ;
        endcase
        return c;
    endfunction

    task automatic add_entry(lc3b_pkg::lc3b_opcode op, lc3b_pkg::lc3b_word addr,
                             lc3b_pkg::lc3b_word data, lc3b_pkg::lc3b_word src,
                             lc3b_pkg::lc3b_word ins, lc3b_pkg::lc3b_reg dst,
                             logic fetch, lc3b_pkg::lc3b_word exp);
        t_op[n_tests] = op;
        t_addr[n_tests] = addr;
        t_data[n_tests] = data;
        t_src[n_tests] = src;
        t_instr[n_tests] = {op, ins[11:0]};
        t_dest[n_tests] = dst;
        t_fetch[n_tests] = fetch;
        t_exp[n_tests] = exp;
        n_tests++;
    endtask

    task automatic build_table;
        lc3b_pkg::lc3b_word r;
        add_entry(lc3b_pkg::op_str, 16'h0010, 16'ha5c3, 0, 16'h0800, 0, 0, 0);
        add_entry(lc3b_pkg::op_ldr, 16'h0010, 0, 0, 16'h0000, 0, 0, 0);
        add_entry(lc3b_pkg::op_stb, 16'h0011, 16'h337e, 0, 16'h0000, 0, 0, 0);
        add_entry(lc3b_pkg::op_stb, 16'h0010, 16'h4419, 0, 16'h0800, 0, 0, 0);
        add_entry(lc3b_pkg::op_ldr, 16'h0010, 0, 0, 16'h0000, 0, 0, 0);
        add_entry(lc3b_pkg::op_ldb, 16'h0010, 0, 0, 16'h0800, 0, 0, 0);
        add_entry(lc3b_pkg::op_ldb, 16'h0011, 0, 0, 16'h0000, 0, 0, 0);
        for (int k = 0; k < 4; k++) begin
            r = 16'($urandom);
            add_entry(lc3b_pkg::op_str, 16'(16'h0020 + 2 * k), r, 0, r, 0, 0, 0);
        end
        add_entry(lc3b_pkg::op_str, 16'h0030, 16'h0024, 0, 16'h0000, 0, 0, 0);
        add_entry(lc3b_pkg::op_str, 16'h0040, 16'h1234, 0, 16'h0800, 0, 1, 0);
        add_entry(lc3b_pkg::op_ldi, 16'h0030, 0, 0, 16'h0000, 0, 1, 0);
        add_entry(lc3b_pkg::op_sti, 16'h0030, 16'hbeef, 0, 16'h0800, 0, 1, 0);
        add_entry(lc3b_pkg::op_ldr, 16'h0024, 0, 0, 16'h0000, 0, 1, 0);
        add_entry(lc3b_pkg::op_ldb, 16'h0023, 0, 0, 16'h0800, 0, 1, 0);
        add_entry(lc3b_pkg::op_stb, 16'h0022, 16'h00c4, 0, 16'h0000, 0, 1, 0);
        add_entry(lc3b_pkg::op_ldr, 16'h0022, 0, 0, 16'h0000, 0, 1, 0);
        // Negative, zero and positive results, each followed by all three tests
        for (int k = 0; k < 3; k++) begin
            r = (k == 0) ? 16'h8001 : (k == 1) ? 16'h0000 : 16'h0005;
            add_entry(lc3b_pkg::op_add, r, 0, 0, 16'h0000, 0, 0, r);
            add_entry(lc3b_pkg::op_br, 0, 0, 0, 16'h0800, 3'b100, 0, 0);
            add_entry(lc3b_pkg::op_br, 0, 0, 0, 16'h0000, 3'b010, 0, 0);
            add_entry(lc3b_pkg::op_br, 0, 0, 0, 16'h0800, 3'b001, 0, 0);
        end
        add_entry(lc3b_pkg::op_shf, 0, 0, 16'($urandom), {10'd0, 2'b00, 4'($urandom)}, 0, 0, 0);
        add_entry(lc3b_pkg::op_shf, 0, 0, 16'($urandom), {10'd2, 2'b01, 4'($urandom)}, 0, 0, 0);
        add_entry(lc3b_pkg::op_shf, 0, 0, 16'h9c41, {10'd0, 2'b11, 4'($urandom)}, 0, 0, 0);
        add_entry(lc3b_pkg::op_lea, 0, 0, 16'h3000, 16'h0000, 0, 0, 16'h3100);
        add_entry(lc3b_pkg::op_jsr, 0, 0, 16'h4a02, 16'h0800, 0, 0, 16'h4a02);
        add_entry(lc3b_pkg::op_jmp, 0, 0, 16'h0200, 16'h0000, 0, 0, 0);
        add_entry(lc3b_pkg::op_trap, 0, 0, 16'h0600, 16'h0020, 0, 1, 16'h0600);
        add_entry(lc3b_pkg::op_ldr, 16'h0026, 0, 0, 16'h0800, 0, 1, 0);
    endtask

    task automatic apply_entry(int i);
        ctrl = decode_ctrl(t_op[i]);
        alu_out = t_addr[i];
        sr2_out = t_data[i];
        sr1_out = t_src[i];
        pc_out = t_src[i];
        br_add_out = t_src[i] + 16'h0100;
        instruction = t_instr[i];
        dest = t_dest[i];
        fetch_on = t_fetch[i];
    endtask

    task automatic check_word(int i, string what, lc3b_pkg::lc3b_word got,
                              lc3b_pkg::lc3b_word exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: test %0d %s got %h expected %h",
                     $time, i, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_entry(int i);
        lc3b_pkg::lc3b_word a;
        lc3b_pkg::lc3b_word w;
        lc3b_pkg::lc3b_word tw;
        logic is_br;
        logic is_jump;
        logic is_trap;
        a = t_addr[i];
        w = shadow[widx(a)];
        tw = shadow[widx({t_instr[i][7:0], 1'b0})];
        is_br = (t_op[i] == lc3b_pkg::op_br);
        is_jump = (t_op[i] == lc3b_pkg::op_jmp) || (t_op[i] == lc3b_pkg::op_jsr);
        is_trap = (t_op[i] == lc3b_pkg::op_trap);
        case (t_op[i])
            lc3b_pkg::op_ldr: check_word(i, "load word", regfilemux_out, w);
            lc3b_pkg::op_ldb: check_word(i, "load byte", regfilemux_out,
                                         {8'h00, a[0] ? w[15:8] : w[7:0]});
            lc3b_pkg::op_ldi: check_word(i, "indirect load", regfilemux_out, shadow[widx(w)]);
            lc3b_pkg::op_add, lc3b_pkg::op_lea, lc3b_pkg::op_jsr, lc3b_pkg::op_trap:
                check_word(i, "write-back", regfilemux_out, t_exp[i]);
            lc3b_pkg::op_shf: check_word(i, "shift", regfilemux_out,
                                         shift_ref(t_src[i], t_instr[i]));
            default: ;
        endcase
        check_word(i, "br_en", 16'(br_en), 16'(is_br && |(t_dest[i] & cc_model)));
        check_word(i, "jmp_jsr_en", 16'(jmp_jsr_en), 16'(is_jump));
        check_word(i, "trap_en", 16'(trap_en), 16'(is_trap));
        check_word(i, "trap_mem", trap_mem, is_trap ? tw : 16'h0000);
        check_word(i, "b11", 16'(b11), 16'(t_instr[i][11]));
        check_word(i, "br_count", br_count, br_tally);
        check_word(i, "br_taken_count", br_taken_count, taken_tally);
    endtask

    // Follows the state the DUT updates at the completion edge
    task automatic update_model(int i);
        lc3b_pkg::lc3b_word a;
        int k;
        a = t_addr[i];
        k = widx(a);
        case (t_op[i])
            lc3b_pkg::op_str: shadow[k] = t_data[i];
            lc3b_pkg::op_stb: begin
                if (a[0]) shadow[k][15:8] = t_data[i][7:0];
                else shadow[k][7:0] = t_data[i][7:0];
            end
            lc3b_pkg::op_sti: begin
                k = widx(shadow[k]);
                shadow[k] = t_data[i];
            end
            lc3b_pkg::op_add: cc_model = {t_addr[i][15], t_addr[i] == 0,
                                          !t_addr[i][15] && t_addr[i] != 0};
            lc3b_pkg::op_br: begin
                br_tally++;
                if (|(t_dest[i] & cc_model)) taken_tally++;
            end
            default: ;
        endcase
        if (t_op[i] inside {lc3b_pkg::op_str, lc3b_pkg::op_stb, lc3b_pkg::op_sti}) begin
            written.push_back(k);
        end
    endtask

    // Random fetch reads of words the data side has already written
    initial begin
        int w;
        forever begin
            @(posedge clk);
            #1;
            if (fetch_on && written.size() > 0) begin
                w = written[$urandom % written.size()];
                fetch_req.read = 1'b1;
                fetch_req.addr = 16'(w * 2);
                @(negedge clk);
                while (!fetch_resp) @(negedge clk);
                fetch_cnt++;
                if (fetch_rdata !== shadow[w]) begin
                    $display("Mismatch at %0t: fetch of %h got %h expected %h",
                             $time, fetch_req.addr, fetch_rdata, shadow[w]);
                    fetch_errs++;
                end
                @(posedge clk);
                #1;
                fetch_req.read = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && fetch_resp && !fetch_req.read) begin
            $display("Fetch port got a response at %0t without a request", $time);
            fetch_errs++;
        end
    end

    // The data port may only see a response while its entry accesses memory
    always @(negedge clk) begin
        if (rst_n && i_dut.data_resp && !(ctrl.mem_read || ctrl.mem_write)) begin
            $display("Data port got a response at %0t without a request", $time);
            stray_errs++;
        end
    end

    initial begin
        wait (table_ready);
        #((n_tests * 20 + 2) * 10);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h06019a41));
        rst_n = 1'b0;
        fetch_req = '0;
        apply_entry_idle();
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            apply_entry(i);
            test_errs = 0;
            @(negedge clk);
            while (stall) @(negedge clk);
            check_entry(i);
            $display("Test %0d %s: %s", i, t_op[i].name(), test_errs == 0 ? "ok" : "failed");
            if (test_errs == 0) pass_cnt++;
            else fail_cnt++;
            @(posedge clk);
            update_model(i);
            #1;
        end
        apply_entry_idle();
        repeat (4) @(negedge clk);
        $display("Tests passed %0d, failed %0d, fetch reads %0d with %0d errors, %0d stray",
                 pass_cnt, fail_cnt, fetch_cnt, fetch_errs, stray_errs);
        if (fail_cnt == 0 && fetch_errs == 0 && stray_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // An ADD without load_cc touches neither memory nor state
    task automatic apply_entry_idle;
        ctrl = decode_ctrl(lc3b_pkg::op_add);
        ctrl.load_cc = 1'b0;
        alu_out = '0;
        pc_out = '0;
        br_add_out = '0;
        sr1_out = '0;
        sr2_out = '0;
        instruction = '0;
        dest = '0;
        fetch_on = 1'b0;
    endtask

endmodule : tb_mem_subsystem

`default_nettype wire
